//--- common/regmap_pkg.sv
package regmap_pkg;

  `include "spi_reg_defines.svh"

  // address field of the command byte
  typedef logic [6:0] reg_addr_t;

  // one register value
  typedef logic [`REG_WIDTH-1:0] reg_data_t;

  // command byte, bit 7 write flag, bits 6:0 address
  typedef logic [7:0] reg_cmd_t;

  // decoder sequence per received frame
  typedef enum logic [1:0] {
    DEC_IDLE,     // waiting for frame_done
    DEC_ISSUE,    // write strobe and read address to bank
    DEC_RESPOND   // build next response frame
  } dec_state_t;

endpackage

//--- common/spi_pkg.sv
package spi_pkg;

  `include "spi_reg_defines.svh"

  // one full frame as seen in the shift register
  typedef logic [`SPI_FRAME_BITS-1:0] spi_frame_t;

  // single byte within a frame
  typedef logic [7:0] spi_byte_t;

  // remaining mclk edges, two per bit
  // must hold 2 * SPI_FRAME_BITS, so 6 bits for a 16-bit frame
  typedef logic [5:0] spi_edge_cnt_t;

endpackage

//--- common/spi_reg_defines.svh
`ifndef SPI_REG_DEFINES_SVH
`define SPI_REG_DEFINES_SVH

// frame geometry, one command byte plus one data byte
`define SPI_FRAME_BYTES 2

// bits shifted per selection, msb first
`define SPI_FRAME_BITS (8 * `SPI_FRAME_BYTES)

// implemented register addresses 0 .. REG_COUNT-1
`define REG_COUNT 8

// control registers sit below this address, status bytes from here up
`define REG_RO_BASE 6

// width of one register in bits
`define REG_WIDTH 8

`endif

//--- files.f
+incdir+common
common/spi_pkg.sv
common/regmap_pkg.sv
spi/spi_slave.sv
spi/spi_frame_decoder.sv
source/reg_bank.sv
source/spi_reg_top.sv
testbench/spi_reg_checker.sv
testbench/tb_spi_reg.sv

//--- source/reg_bank.sv
`timescale 1ns/1ps

`include "spi_reg_defines.svh"

module reg_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  regmap_pkg::reg_addr_t wr_addr,
  input  regmap_pkg::reg_data_t wr_data,
  input  regmap_pkg::reg_addr_t rd_addr,
  input  logic [`REG_WIDTH*(`REG_COUNT-`REG_RO_BASE)-1:0] status_in,   // byte 0 at addr 6
  output regmap_pkg::reg_data_t rd_data,
  output logic [`REG_WIDTH*`REG_RO_BASE-1:0]              reg_out      // ctrl 0 in low byte
);

  import regmap_pkg::*;

  localparam int NUM_CTRL = `REG_RO_BASE;
  localparam int NUM_STAT = `REG_COUNT - `REG_RO_BASE;

  reg_data_t  ctrl_q [NUM_CTRL];     // read/write control registers
  reg_data_t  stat_b [NUM_STAT];     // status bytes, split from status_in
  logic       wr_hit;                // write targets a control register
  logic       rd_ctrl;               // read from control range
  logic       rd_stat;               // read from status range
  logic [2:0] ctrl_idx_wr;
  logic [2:0] ctrl_idx_rd;
  logic [2:0] stat_idx;

  assign wr_hit  = wr_en && (wr_addr < reg_addr_t'(`REG_RO_BASE));   // status is read only
  assign rd_ctrl = (rd_addr < reg_addr_t'(`REG_RO_BASE));
  assign rd_stat = !rd_ctrl && (rd_addr < reg_addr_t'(`REG_COUNT));

  assign ctrl_idx_wr = wr_addr[2:0];
  assign ctrl_idx_rd = rd_addr[2:0];
  assign stat_idx    = rd_addr[2:0] - 3'(`REG_RO_BASE);   // 6 -> 0, 7 -> 1

  // control registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CTRL; i++) begin
        ctrl_q[i] <= '0;
      end
    end else if (wr_hit) begin
      ctrl_q[ctrl_idx_wr] <= wr_data;
    end
  end

  // flat views of control and status
  genvar g;
  generate
    for (g = 0; g < NUM_CTRL; g++) begin : g_ctrl_out
      assign reg_out[g*`REG_WIDTH +: `REG_WIDTH] = ctrl_q[g];
    end
    for (g = 0; g < NUM_STAT; g++) begin : g_stat_in
      assign stat_b[g] = status_in[g*`REG_WIDTH +: `REG_WIDTH];
    end
  endgenerate

  // read mux with write bypass
  always_comb begin
    rd_data = '0;   // unmapped addresses read zero
    if (rd_ctrl) begin
      if (wr_hit && (wr_addr == rd_addr)) begin
        rd_data = wr_data;   // same-cycle write seen by read
      end else begin
        rd_data = ctrl_q[ctrl_idx_rd];
      end
    end else if (rd_stat) begin
      rd_data = stat_b[stat_idx[0]];
    end
  end

endmodule

//--- source/spi_reg_top.sv
`timescale 1ns/1ps

`include "spi_reg_defines.svh"

module spi_reg_top (
  input  logic clk,
  input  logic rst_n,
  input  logic cpol,
  input  logic cpha,
  input  logic select,     // spi chip select, active high
  input  logic mclk,
  input  logic mosi,
  output logic miso,
  output logic busy,       // frame in progress
  input  logic [`REG_WIDTH*(`REG_COUNT-`REG_RO_BASE)-1:0] status_in,  // addr 6 and 7
  output logic [`REG_WIDTH*`REG_RO_BASE-1:0]              reg_out     // control regs 0..5
);

  import spi_pkg::*;
  import regmap_pkg::*;

  spi_frame_t rx_frame;     // slave -> decoder
  spi_frame_t tx_frame;     // decoder -> slave
  logic       frame_done;
  logic       wr_en;        // decoder -> bank
  reg_addr_t  wr_addr;
  reg_data_t  wr_data;
  reg_addr_t  rd_addr;
  reg_data_t  rd_data;      // bank -> decoder

  spi_slave slave_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpol       (cpol),
    .cpha       (cpha),
    .select     (select),
    .mclk       (mclk),
    .mosi       (mosi),
    .tx_frame   (tx_frame),
    .miso       (miso),
    .rx_frame   (rx_frame),
    .busy       (busy),
    .frame_done (frame_done)
  );

  spi_frame_decoder decoder_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_frame   (rx_frame),
    .frame_done (frame_done),
    .rd_data    (rd_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .tx_frame   (tx_frame)
  );

  reg_bank bank_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .status_in (status_in),
    .rd_data   (rd_data),
    .reg_out   (reg_out)
  );

endmodule

//--- spi/spi_frame_decoder.sv
`timescale 1ns/1ps

module spi_frame_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_pkg::spi_frame_t   rx_frame,    // frame from slave
  input  logic                  frame_done,  // rx_frame complete
  input  regmap_pkg::reg_data_t rd_data,     // combinational from bank
  output logic                  wr_en,
  output regmap_pkg::reg_addr_t wr_addr,
  output regmap_pkg::reg_data_t wr_data,
  output regmap_pkg::reg_addr_t rd_addr,
  output spi_pkg::spi_frame_t   tx_frame     // response for next selection
);

  import spi_pkg::*;
  import regmap_pkg::*;

  dec_state_t state_q;
  reg_cmd_t   cmd_q;       // command byte of last complete frame
  reg_data_t  data_q;      // write data of last complete frame
  spi_byte_t  rx_cmd;
  spi_byte_t  rx_data;
  logic       cmd_write;   // write flag of held command

  assign {rx_cmd, rx_data} = rx_frame;   // msb byte arrives first

  assign cmd_write = cmd_q[7];

  // bank ports straight from the held command
  assign wr_en   = (state_q == DEC_ISSUE) && cmd_write;   // single cycle strobe
  assign wr_addr = cmd_q[6:0];
  assign wr_data = data_q;
  assign rd_addr = cmd_q[6:0];   // kept through respond, so read sees the write

  // command capture, payload only
  always_ff @(posedge clk) begin
    if ((state_q == DEC_IDLE) && frame_done) begin
      cmd_q  <= rx_cmd;
      data_q <= rx_data;
    end
  end

  // issue / respond sequence
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= DEC_IDLE;
      tx_frame <= '0;
    end else begin
      case (state_q)
        DEC_IDLE: begin
          if (frame_done) begin
            state_q <= DEC_ISSUE;
          end
        end
        DEC_ISSUE: begin
          state_q <= DEC_RESPOND;   // write lands at end of this cycle
        end
        DEC_RESPOND: begin
          tx_frame <= {cmd_q, rd_data};   // echo command plus read value
          state_q  <= DEC_IDLE;
        end
        default: begin
          state_q <= DEC_IDLE;
        end
      endcase
    end
  end

endmodule

//--- spi/spi_slave.sv
`timescale 1ns/1ps

`include "spi_reg_defines.svh"

module spi_slave (
  input  logic               clk,        // at least 2x mclk
  input  logic               rst_n,
  input  logic               cpol,       // idle level of mclk
  input  logic               cpha,       // 0 sample on leading edge, 1 on trailing
  input  logic               select,     // active high chip select
  input  logic               mclk,
  input  logic               mosi,
  input  spi_pkg::spi_frame_t tx_frame,  // latched on start
  output logic               miso,
  output spi_pkg::spi_frame_t rx_frame,  // valid from frame_done to next start
  output logic               busy,
  output logic               frame_done  // one cycle after last edge
);

  import spi_pkg::*;

  localparam int FRAME_MSB = `SPI_FRAME_BITS - 1;

  logic [3:0]    sel_hist;     // select history, newest in bit 0
  logic [1:0]    mclk_hist;    // mclk history for edge detect
  logic          mosi_q;       // mosi aligned with mclk_hist[0]
  logic          start;
  logic          mclk_rise;
  logic          mclk_fall;
  logic          mclk_tick;    // any mclk edge
  logic          lead_edge;    // idle -> active
  logic          trail_edge;   // active -> idle
  logic          sample_edge;
  logic          setup_edge;
  spi_edge_cnt_t edge_cnt;     // edges left in this frame
  spi_frame_t    shift_q;      // tx out of msb, rx into lsb

  // input synchronizers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_hist  <= '0;
      mclk_hist <= '0;
      mosi_q    <= 1'b0;
    end else begin
      sel_hist  <= {sel_hist[2:0], select};
      mclk_hist <= {mclk_hist[0], mclk};
      mosi_q    <= mosi;
    end
  end

  assign start = (sel_hist == 4'b0011);   // select high for two samples

  assign mclk_rise  = (mclk_hist == 2'b01);
  assign mclk_fall  = (mclk_hist == 2'b10);
  assign mclk_tick  = mclk_rise | mclk_fall;
  assign lead_edge  = cpol ? mclk_fall : mclk_rise;
  assign trail_edge = cpol ? mclk_rise : mclk_fall;
  // cpha picks which edge captures and which edge shifts out
  assign sample_edge = cpha ? trail_edge : lead_edge;
  assign setup_edge  = cpha ? lead_edge : trail_edge;

  assign busy = start | ((edge_cnt != '0) & sel_hist[0]);   // drops at once on deselect

  // edge counter and frame end
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      edge_cnt   <= '0;
      frame_done <= 1'b0;
    end else if (start) begin
      edge_cnt   <= spi_edge_cnt_t'(2 * `SPI_FRAME_BITS);   // two edges per bit
      frame_done <= 1'b0;
    end else if (!busy) begin
      edge_cnt   <= '0;           // aborted or finished frame
      frame_done <= 1'b0;
    end else if (mclk_tick) begin
      edge_cnt   <= edge_cnt - 1'b1;
      frame_done <= (edge_cnt == spi_edge_cnt_t'(1));   // last edge of frame
    end else begin
      frame_done <= 1'b0;
    end
  end

  // shift register, loaded with response then filled with mosi
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= tx_frame;
    end else if (busy && sample_edge) begin
      shift_q <= {shift_q[FRAME_MSB-1:0], mosi_q};
    end
  end

  assign rx_frame = shift_q;

  // miso holds its value while deselected
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      miso <= 1'b0;
    end else if (start) begin
      miso <= tx_frame[FRAME_MSB];   // first bit ready before first edge
    end else if (busy && setup_edge) begin
      miso <= shift_q[FRAME_MSB];
    end
  end

endmodule

//--- testbench/spi_reg_checker.sv
`timescale 1ns/1ps

`include "spi_reg_defines.svh"

module spi_reg_checker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cpol,
  input  logic                               cpha,
  input  logic                               select,
  input  logic                               mclk,
  input  logic                               miso,
  input  logic [`REG_WIDTH*`REG_RO_BASE-1:0] reg_out,
  input  spi_pkg::spi_frame_t                exp_frame,    // response due in this frame
  input  logic [`REG_WIDTH*`REG_RO_BASE-1:0] exp_reg_out,
  input  logic                               reg_chk,      // compare reg_out this cycle
  input  logic                               test_done,    // one cycle at end of a test
  input  int                                 test_id,      // mode * 4 + kind
  output int                                 chk_count,
  output int                                 err_count
);

  import spi_pkg::*;

  logic       sel_d;       // select one clk back
  logic       mclk_d;      // mclk one clk back
  logic       lead;        // edge leaves the idle level
  spi_frame_t cap;         // miso bits, msb first
  int         edges;       // mclk edges seen in this selection
  int         test_chk;
  int         test_err;

  function automatic string kind_name(input int id);
    case (id % 4)
      0:       return "control write and read";
      1:       return "status read only";
      2:       return "unmapped addresses";
      default: return "aborted frames";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [47:0] got,
                             input logic [47:0] exp);
    chk_count++;
    test_chk++;
    if (got !== exp) begin
      err_count++;
      test_err++;
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // pins sampled on rising clk, all tb drives settle on falling clk
  always @(posedge clk) begin
    if (!rst_n) begin
      sel_d     = 1'b0;
      mclk_d    = mclk;
      edges     = 0;
      cap       = '0;
      chk_count = 0;
      err_count = 0;
      test_chk  = 0;
      test_err  = 0;
    end else begin
      if (select && !sel_d) begin
        edges = 0;   // new selection
        cap   = '0;
      end
      if (select && sel_d && (mclk !== mclk_d)) begin
        lead = (mclk !== cpol);
        if (lead != cpha) begin
          cap = {cap[`SPI_FRAME_BITS-2:0], miso};   // sample edge of this mode
        end
        edges++;
      end
      // only full frames carry a response worth checking
      if (!select && sel_d && (edges == 2 * `SPI_FRAME_BITS)) begin
        check_value("miso frame", 48'(cap), 48'(exp_frame));
      end
      if (reg_chk) begin
        check_value("reg_out", reg_out, exp_reg_out);
      end
      if (test_done) begin
        $display("test %0d, mode %0d, %s: %0d checks, %0d errors",
                 test_id, test_id / 4, kind_name(test_id), test_chk, test_err);
        test_chk = 0;
        test_err = 0;
      end
      sel_d  = select;
      mclk_d = mclk;
    end
  end

endmodule

//--- testbench/tb_spi_reg.sv
`timescale 1ns/1ps

`include "spi_reg_defines.svh"

module tb_spi_reg;

  import spi_pkg::*;

  localparam int CTRL_BITS  = `REG_WIDTH * `REG_RO_BASE;
  localparam int STAT_BITS  = `REG_WIDTH * (`REG_COUNT - `REG_RO_BASE);
  localparam int FULL_EDGES = 2 * `SPI_FRAME_BITS;
  localparam int HALF_MCLK  = 3;    // clk cycles per mclk phase
  localparam int GAP_CYCLES = 6;    // select low between frames
  localparam int WAIT_LIMIT = 20;   // clk cycles before a wait gives up

  logic                 clk;
  logic                 rst_n;
  logic                 cpol;
  logic                 cpha;
  logic                 select;
  logic                 mclk;
  logic                 mosi;
  logic                 miso;
  logic                 busy;
  logic [STAT_BITS-1:0] status_in;
  logic [CTRL_BITS-1:0] reg_out;

  logic [7:0]           ctrl_m [`REG_RO_BASE];   // model of control registers
  spi_frame_t           resp_m;                  // next response the slave should send
  spi_frame_t           exp_frame;
  logic [CTRL_BITS-1:0] exp_reg_out;
  logic                 reg_chk;
  logic                 test_done;
  int                   test_id;
  int                   chk_count;
  int                   err_count;
  logic                 timed_out;
  int unsigned          seed;
  int                   m;
  int                   k;

  spi_reg_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpol      (cpol),
    .cpha      (cpha),
    .select    (select),
    .mclk      (mclk),
    .mosi      (mosi),
    .miso      (miso),
    .busy      (busy),
    .status_in (status_in),
    .reg_out   (reg_out)
  );

  spi_reg_checker checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpol        (cpol),
    .cpha        (cpha),
    .select      (select),
    .mclk        (mclk),
    .miso        (miso),
    .reg_out     (reg_out),
    .exp_frame   (exp_frame),
    .exp_reg_out (exp_reg_out),
    .reg_chk     (reg_chk),
    .test_done   (test_done),
    .test_id     (test_id),
    .chk_count   (chk_count),
    .err_count   (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  // control below 6 then status at 6 and 7 and zero above
  function automatic logic [7:0] model_read(input logic [6:0] a);
    if (a < `REG_RO_BASE) return ctrl_m[a[2:0]];
    if (a < `REG_COUNT) return status_in[(a - `REG_RO_BASE) * 8 +: 8];
    return 8'h00;
  endfunction

  function automatic logic [CTRL_BITS-1:0] model_regs();
    logic [CTRL_BITS-1:0] v;
    for (int i = 0; i < `REG_RO_BASE; i++) begin
      v[i*8 +: 8] = ctrl_m[i];   // control 0 in low byte
    end
    return v;
  endfunction

  task automatic model_update(input logic [7:0] cmd, input logic [7:0] data);
    if (cmd[7] && (cmd[6:0] < `REG_RO_BASE)) ctrl_m[cmd[2:0]] = data;
    resp_m = {cmd, model_read(cmd[6:0])};   // echo plus value after the write
  endtask

  task automatic wait_busy(input logic level, output logic ok);
    int n;
    n = 0;
    while ((busy !== level) && (n < WAIT_LIMIT)) begin
      @(negedge clk);
      n++;
    end
    ok = (busy === level);
    if (!ok) begin
      $display("ERROR: busy did not become %b within %0d clk cycles", level, n);
      timed_out = 1'b1;
    end
  endtask

  // one selection that aborts when n_edges is below FULL_EDGES
  task automatic run_frame(input logic [7:0] cmd, input logic [7:0] data, input int n_edges);
    spi_frame_t fr;
    logic       ok;
    int         e;
    fr        = {cmd, data};
    exp_frame = resp_m;
    select    = 1'b1;
    mosi      = cpha ? 1'b0 : fr[`SPI_FRAME_BITS-1];   // mode 0 and 2 need bit 15 early
    wait_busy(1'b1, ok);
    if (!ok) return;
    for (e = 0; e < n_edges; e++) begin
      repeat (HALF_MCLK) @(negedge clk);
      mclk = ~mclk;
      if (cpha && !e[0]) begin
        mosi = fr[`SPI_FRAME_BITS-1-e/2];       // leading edge sets up
      end else if (!cpha && e[0] && (e < FULL_EDGES - 1)) begin
        mosi = fr[`SPI_FRAME_BITS-1-(e+1)/2];   // trailing edge sets up next bit
      end
    end
    repeat (HALF_MCLK) @(negedge clk);
    if (n_edges < FULL_EDGES) select = 1'b0;   // deselect mid frame
    wait_busy(1'b0, ok);
    if (!ok) return;
    select = 1'b0;
    mclk   = cpol;   // idle again after an odd abort
    if (n_edges == FULL_EDGES) model_update(cmd, data);
    repeat (GAP_CYCLES) @(negedge clk);
    exp_reg_out = model_regs();
    reg_chk     = 1'b1;
    @(negedge clk);
    reg_chk     = 1'b0;
  endtask

  task automatic run_test(input int id);
    int         i;
    logic [6:0] a;
    case (id % 4)
      0: for (i = 0; (i < 6) && !timed_out; i++) begin
        a = 7'($urandom_range(`REG_RO_BASE - 1));
        run_frame({1'b1, a}, 8'($urandom), FULL_EDGES);
        run_frame({1'b0, a}, 8'($urandom), FULL_EDGES);   // read back next frame
      end
      1: for (i = 0; (i < 6) && !timed_out; i++) begin
        status_in = STAT_BITS'($urandom);   // new status between frames
        a = 7'($urandom_range(`REG_COUNT - 1, `REG_RO_BASE));
        run_frame({1'($urandom_range(1)), a}, 8'($urandom), FULL_EDGES);
      end
      2: for (i = 0; (i < 6) && !timed_out; i++) begin
        a = 7'($urandom_range(127, `REG_COUNT));
        run_frame({1'($urandom_range(1)), a}, 8'($urandom), FULL_EDGES);
      end
      default: for (i = 0; (i < 4) && !timed_out; i++) begin
        a = 7'($urandom_range(`REG_RO_BASE - 1));
        run_frame({1'b1, a}, 8'($urandom), int'($urandom_range(FULL_EDGES - 1, 1)));
        run_frame({1'b0, a}, 8'($urandom), FULL_EDGES);
      end
    endcase
    test_id   = id;
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin
    rst_n       = 1'b0;
    cpol        = 1'b0;
    cpha        = 1'b0;
    select      = 1'b0;
    mclk        = 1'b0;
    mosi        = 1'b0;
    status_in   = '0;
    exp_frame   = '0;
    exp_reg_out = '0;
    reg_chk     = 1'b0;
    test_done   = 1'b0;
    test_id     = 0;
    timed_out   = 1'b0;
    seed        = 32'h8bd1;
    void'($urandom(seed));
    resp_m      = '0;   // tx_frame resets to zero
    for (int i = 0; i < `REG_RO_BASE; i++) ctrl_m[i] = 8'h00;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (m = 0; (m < 4) && !timed_out; m++) begin
      {cpol, cpha} = m[1:0];
      mclk         = m[1];   // idle level of the new mode
      repeat (4) @(negedge clk);
      for (k = 0; (k < 4) && !timed_out; k++) run_test(m * 4 + k);
    end
    repeat (4) @(negedge clk);
    $display("closing: %0d checks, %0d errors, timeout %0d", chk_count, err_count, timed_out);
    if (!timed_out && (err_count == 0) && (chk_count > 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
